//--- hw/esp_cmd_engine.sv
`include "trs_config.svh"

module esp_cmd_engine (
  input  logic                   clk,
  input  logic                   rst_n,
  input  trs_bus_pkg::z80_data_t rx_byte,
  input  logic                   rx_valid,
  input  logic                   cs_start,
  input  logic [3:0]             conf,
  input  logic                   ram_grant,
  input  logic                   ram_rvalid,
  input  trs_bus_pkg::z80_data_t ram_rdata,
  output trs_bus_pkg::z80_data_t tx_byte,
  output logic                   tx_load,
  output logic                   ram_req,
  output logic                   ram_we,
  output trs_bus_pkg::ram_addr_t ram_addr,
  output trs_bus_pkg::z80_data_t ram_wdata,
  output logic                   full_addr,
  output logic                   led_red,
  output logic                   led_green,
  output logic                   led_blue
);
  import trs_bus_pkg::*;
  import esp_cmd_pkg::*;

  parse_state_t state;
  esp_opcode_t  cmd;
  z80_data_t    params [`TRS_MAX_PARAMS];
  logic [1:0]   param_idx;
  logic [1:0]   param_cnt;
  logic         exec;   // command complete, one cycle

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= idle;
      param_idx <= 2'd0;
      param_cnt <= 2'd0;
      exec      <= 1'b0;
    end else begin
      exec <= 1'b0;
      if (cs_start) begin
        state     <= idle;    // drops any half-received command
        param_idx <= 2'd0;
      end else if (rx_valid) begin
        case (state)
          idle: begin
            param_idx <= 2'd0;
            case (rx_byte)
              bram_poke: begin
                param_cnt <= 2'd3;
                state     <= read_params;
              end
              bram_peek: begin
                param_cnt <= 2'd2;
                state     <= read_params;
              end
              set_led, set_full_addr: begin
                param_cnt <= 2'd1;
                state     <= read_params;
              end
              get_cookie, get_version, get_config: exec <= 1'b1;
              default: ;  // unknown opcode
            endcase
          end
          read_params: begin
            param_idx <= param_idx + 2'd1;
            if (param_idx == param_cnt - 2'd1) begin
              exec  <= 1'b1;
              state <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && !cs_start) begin
      if (state == idle)
        cmd <= esp_opcode_t'(rx_byte);
      else
        params[param_idx] <= rx_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_load   <= 1'b0;
      ram_req   <= 1'b0;
      ram_we    <= 1'b0;
      full_addr <= 1'b0;
      led_red   <= 1'b0;
      led_green <= 1'b0;
      led_blue  <= 1'b0;
    end else begin
      tx_load <= ram_rvalid;  // peek data goes straight out
      if (ram_grant)
        ram_req <= 1'b0;
      if (exec) begin
        case (cmd)
          set_led:       {led_blue, led_green, led_red} <= params[0][2:0];
          set_full_addr: full_addr <= |params[0];
          bram_poke: begin
            ram_req <= 1'b1;
            ram_we  <= 1'b1;
          end
          bram_peek: begin
            ram_req <= 1'b1;
            ram_we  <= 1'b0;
          end
          get_cookie, get_version, get_config: tx_load <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ram_rvalid)
      tx_byte <= ram_rdata;
    else if (exec) begin
      case (cmd)
        get_cookie:  tx_byte <= `TRS_COOKIE;
        get_version: tx_byte <= {`TRS_VERSION_MAJOR, `TRS_VERSION_MINOR};
        get_config:  tx_byte <= {4'b0000, conf};
        default: ;
      endcase
    end
  end

  // params are addr lo, addr hi, data
  assign ram_addr  = {params[1][6:0], params[0]};
  assign ram_wdata = params[2];

  a_param_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    (state == read_params) |-> (param_idx < `TRS_MAX_PARAMS));

endmodule

//--- hw/esp_cmd_pkg.sv
package esp_cmd_pkg;

  // opcodes understood over the spi link, numbering follows the esp firmware
  typedef enum logic [7:0] {
    get_cookie    = 8'd0,
    bram_poke     = 8'd1,
    bram_peek     = 8'd2,
    set_full_addr = 8'd14,
    get_version   = 8'd15,
    set_led       = 8'd26,
    get_config    = 8'd27
  } esp_opcode_t;

  // opcode byte first, then parameter bytes
  typedef enum logic {
    idle        = 1'b0,
    read_params = 1'b1
  } parse_state_t;

endpackage

//--- hw/ram_arbiter.sv
`include "trs_config.svh"

module ram_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   z80_req,
  input  logic                   z80_we,
  input  trs_bus_pkg::ram_addr_t z80_addr,
  input  trs_bus_pkg::z80_data_t z80_wdata,
  input  logic                   esp_req,
  input  logic                   esp_we,
  input  trs_bus_pkg::ram_addr_t esp_addr,
  input  trs_bus_pkg::z80_data_t esp_wdata,
  output logic                   z80_grant,
  output logic                   z80_rvalid,
  output logic                   esp_grant,
  output logic                   esp_rvalid,
  output trs_bus_pkg::z80_data_t rdata
);
  import trs_bus_pkg::*;

  z80_data_t mem [2**`TRS_RAM_ADDR_W];

  ram_req_t  owner;       // requester of the last access
  logic      rd_pending;  // last access was a read
  logic      any_grant;
  logic      sel_we;
  ram_addr_t sel_addr;
  z80_data_t sel_wdata;

  // z80 cannot wait, so it always wins
  assign z80_grant = z80_req;
  assign esp_grant = esp_req & ~z80_req;
  assign any_grant = z80_grant | esp_grant;

  assign sel_we    = z80_grant ? z80_we    : esp_we;
  assign sel_addr  = z80_grant ? z80_addr  : esp_addr;
  assign sel_wdata = z80_grant ? z80_wdata : esp_wdata;

  always_ff @(posedge clk) begin
    if (any_grant) begin
      if (sel_we)
        mem[sel_addr] <= sel_wdata;
      rdata <= mem[sel_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner      <= req_z80;
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= any_grant & ~sel_we;
      if (any_grant)
        owner <= z80_grant ? req_z80 : req_esp;
    end
  end

  assign z80_rvalid = rd_pending & (owner == req_z80);
  assign esp_rvalid = rd_pending & (owner == req_esp);

  // a waiting esp request stays up until served
  a_esp_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (esp_req && !esp_grant) |=> esp_req);

endmodule

//--- hw/spi_byte_link.sv
`include "trs_config.svh"

module spi_byte_link (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   mosi,
  input  trs_bus_pkg::z80_data_t tx_byte,
  input  logic                   tx_load,
  output trs_bus_pkg::z80_data_t rx_byte,
  output logic                   rx_valid,
  output logic                   cs_start,
  output logic                   miso
);
  import trs_bus_pkg::*;

  localparam int S = `TRS_SYNC_STAGES;

  logic [S:0]   sck_sr;   // one extra stage for edge detect
  logic [S:0]   cs_sr;
  logic [S-1:0] mosi_sr;
  logic         sck_rise;
  logic         sck_fall;
  logic         cs_active;
  logic [2:0]   bit_cnt;
  z80_data_t    rx_shift;
  z80_data_t    tx_shift;

  assign sck_rise  = sck_sr[S-1] & ~sck_sr[S];
  assign sck_fall  = ~sck_sr[S-1] & sck_sr[S];
  assign cs_active = ~cs_sr[S-1];
  assign cs_start  = cs_sr[S] & ~cs_sr[S-1];  // falling cs_n

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_sr   <= '0;
      cs_sr    <= '1;   // deselected
      mosi_sr  <= '0;
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      sck_sr  <= {sck_sr[S-1:0], sck};
      cs_sr   <= {cs_sr[S-1:0], cs_n};
      mosi_sr <= {mosi_sr[S-2:0], mosi};
      if (!cs_active)
        bit_cnt <= 3'd0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
    end
  end

  // mode 0, msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_sr[S-1]};
    if (tx_load)
      tx_shift <= tx_byte;
    else if (cs_active && sck_fall && (bit_cnt != 3'd0))
      tx_shift <= {tx_shift[6:0], 1'b0};  // falling edge after the 8th rise is skipped
  end

  assign rx_byte = rx_shift;
  assign miso    = cs_active & tx_shift[7];

  // a reply only loads between bytes
  a_tx_load_gap: assert property (@(posedge clk) disable iff (!rst_n)
    tx_load |-> (bit_cnt == 3'd0));

endmodule

//--- hw/trs_bus_pkg.sv
`include "trs_config.svh"

package trs_bus_pkg;

  // z80 side of the expansion connector
  typedef logic [15:0] z80_addr_t;
  typedef logic [7:0] z80_data_t;

  // offset into the shared expansion ram
  typedef logic [`TRS_RAM_ADDR_W-1:0] ram_addr_t;

  // who owns the current ram access
  typedef enum logic {
    req_z80 = 1'b0,
    req_esp = 1'b1
  } ram_req_t;

endpackage

//--- hw/trs_config.svh
`ifndef TRS_CONFIG_SVH
`define TRS_CONFIG_SVH

// expansion ram is 32 KB
`define TRS_RAM_ADDR_W 15

// identity bytes returned to the ESP
`define TRS_COOKIE 8'haf
`define TRS_VERSION_MAJOR 3'd0
`define TRS_VERSION_MINOR 5'd3

`define TRS_MAX_PARAMS 3   // poke needs the most

// input conditioning
`define TRS_SYNC_STAGES 2
`define TRS_FILTER_LEN 2   // stable samples before a z80 strobe counts

`endif

//--- hw/trs_io_top.sv
`include "trs_config.svh"

module trs_io_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   mosi,
  input  logic                   rd_n,
  input  logic                   wr_n,
  input  trs_bus_pkg::z80_addr_t a,
  input  trs_bus_pkg::z80_data_t d_in,
  input  logic [3:0]             conf,
  output logic                   miso,
  output trs_bus_pkg::z80_data_t d_out,
  output logic                   d_oe,
  output logic                   led_red,
  output logic                   led_green,
  output logic                   led_blue
);
  import trs_bus_pkg::*;

  z80_data_t rx_byte, tx_byte;
  logic      rx_valid, tx_load, cs_start, full_addr;
  logic      z80_req, z80_we, z80_grant, z80_rvalid;
  logic      esp_req, esp_we, esp_grant, esp_rvalid;
  ram_addr_t z80_addr, esp_addr;
  z80_data_t z80_wdata, esp_wdata, ram_rdata;

  spi_byte_link u_link (
    .clk, .rst_n, .sck, .cs_n, .mosi, .tx_byte, .tx_load,
    .rx_byte, .rx_valid, .cs_start, .miso
  );

  esp_cmd_engine u_engine (
    .clk, .rst_n, .rx_byte, .rx_valid, .cs_start, .conf,
    .ram_grant(esp_grant), .ram_rvalid(esp_rvalid), .ram_rdata,
    .tx_byte, .tx_load,
    .ram_req(esp_req), .ram_we(esp_we), .ram_addr(esp_addr), .ram_wdata(esp_wdata),
    .full_addr, .led_red, .led_green, .led_blue
  );

  z80_mem_port u_z80 (
    .clk, .rst_n, .rd_n, .wr_n, .a, .d_in, .full_addr,
    .ram_grant(z80_grant), .ram_rvalid(z80_rvalid), .ram_rdata,
    .ram_req(z80_req), .ram_we(z80_we), .ram_addr(z80_addr), .ram_wdata(z80_wdata),
    .d_out, .d_oe
  );

  ram_arbiter u_arb (
    .clk, .rst_n,
    .z80_req, .z80_we, .z80_addr, .z80_wdata,
    .esp_req, .esp_we, .esp_addr, .esp_wdata,
    .z80_grant, .z80_rvalid, .esp_grant, .esp_rvalid,
    .rdata(ram_rdata)
  );

endmodule

//--- hw/z80_mem_port.sv
`include "trs_config.svh"

module z80_mem_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rd_n,
  input  logic                   wr_n,
  input  trs_bus_pkg::z80_addr_t a,
  input  trs_bus_pkg::z80_data_t d_in,
  input  logic                   full_addr,
  input  logic                   ram_grant,
  input  logic                   ram_rvalid,
  input  trs_bus_pkg::z80_data_t ram_rdata,
  output logic                   ram_req,
  output logic                   ram_we,
  output trs_bus_pkg::ram_addr_t ram_addr,
  output trs_bus_pkg::z80_data_t ram_wdata,
  output trs_bus_pkg::z80_data_t d_out,
  output logic                   d_oe
);
  localparam int S = `TRS_SYNC_STAGES;
  localparam int L = `TRS_FILTER_LEN;

  logic [S-1:0] rd_sync, wr_sync;
  logic [L-1:0] rd_hist, wr_hist;
  logic         rd_f, wr_f;       // filtered strobes, active low
  logic         rd_start, wr_start, rd_end;
  logic         ram_sel, rom_sel;

  // model I map: upper 32K, or 48K plus the low 12K for reads
  assign ram_sel = full_addr ? (a[15] | a[14]) : a[15];
  assign rom_sel = full_addr & ~a[15] & ~a[14] & ~(a[13] & a[12]);  // below 3000h

  assign rd_start = rd_f & ~(|rd_hist);
  assign wr_start = wr_f & ~(|wr_hist);
  assign rd_end   = ~rd_f & (&rd_hist);
  assign ram_addr = a[`TRS_RAM_ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_sync <= '1;
      wr_sync <= '1;
      rd_hist <= '1;
      wr_hist <= '1;
      rd_f    <= 1'b1;
      wr_f    <= 1'b1;
      ram_req <= 1'b0;
      ram_we  <= 1'b0;
      d_oe    <= 1'b0;
    end else begin
      rd_sync <= {rd_sync[S-2:0], rd_n};
      wr_sync <= {wr_sync[S-2:0], wr_n};
      rd_hist <= {rd_hist[L-2:0], rd_sync[S-1]};
      wr_hist <= {wr_hist[L-2:0], wr_sync[S-1]};
      // glitches shorter than the window keep the old level
      if (&rd_hist)
        rd_f <= 1'b1;
      else if (~(|rd_hist))
        rd_f <= 1'b0;
      if (&wr_hist)
        wr_f <= 1'b1;
      else if (~(|wr_hist))
        wr_f <= 1'b0;

      if (ram_grant)
        ram_req <= 1'b0;
      if (wr_start && ram_sel) begin
        ram_req <= 1'b1;
        ram_we  <= 1'b1;
      end else if (rd_start && (ram_sel || rom_sel)) begin
        ram_req <= 1'b1;
        ram_we  <= 1'b0;
        d_oe    <= 1'b1;
      end
      if (rd_end)
        d_oe <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_start)
      ram_wdata <= d_in;  // data is stable once wr_n is low
    if (ram_rvalid)
      d_out <= ram_rdata;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_trs_io -f sim.f -o tb_trs_io

./obj_dir/tb_trs_io > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  exit 0
fi
exit 1

//--- sim.f
+incdir+hw
hw/trs_bus_pkg.sv
hw/esp_cmd_pkg.sv
hw/spi_byte_link.sv
hw/esp_cmd_engine.sv
hw/z80_mem_port.sv
hw/ram_arbiter.sv
hw/trs_io_top.sv
sim/tb_trs_io.sv

//--- sim/tb_trs_io.sv
module tb_trs_io;
  timeunit 1ns;
  timeprecision 100ps;

  import trs_bus_pkg::*;
  import esp_cmd_pkg::*;

  localparam int MAX_ENTRIES = 20;
  localparam int WORST_ENTRY = 500;  // a peek with reply is about 420 clk
  localparam int MAX_CYCLES  = 2 * MAX_ENTRIES * WORST_ENTRY;
  localparam logic [3:0] CONF_VAL = 4'h6;

  // operation kinds
  localparam int K_SPI   = 0;
  localparam int K_WR    = 1;
  localparam int K_RD    = 2;
  localparam int K_ABORT = 3;

  // what an entry checks
  localparam int C_NONE  = 0;
  localparam int C_REPLY = 1;
  localparam int C_LED   = 2;
  localparam int C_READ  = 3;
  localparam int C_NO_OE = 4;

  logic       clk = 1'b0;
  logic       rst_n, sck, cs_n, mosi, rd_n, wr_n;
  z80_addr_t  a;
  z80_data_t  d_in;
  logic [3:0] conf;
  logic       miso, d_oe, led_red, led_green, led_blue;
  z80_data_t  d_out;

  // stimulus table
  string       t_name [MAX_ENTRIES];
  int          t_kind [MAX_ENTRIES];
  esp_opcode_t t_op   [MAX_ENTRIES];
  logic [15:0] t_addr [MAX_ENTRIES];  // ram offset for spi, bus address for z80
  logic [7:0]  t_data [MAX_ENTRIES];
  int          t_chk  [MAX_ENTRIES];
  logic [7:0]  t_exp  [MAX_ENTRIES];
  int          n_entries = 0;

  logic [31:0] lfsr = 32'h4292_af09;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;

  trs_io_top uut (
    .clk, .rst_n, .sck, .cs_n, .mosi, .rd_n, .wr_n, .a, .d_in, .conf,
    .miso, .d_out, .d_oe, .led_red, .led_green, .led_blue
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic wait_clk(input int n);
    repeat (n) @(negedge clk);
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};  // one step per bit
    end
    return b;
  endfunction

  task automatic add_entry(input string name, input int kind, input esp_opcode_t op,
                           input logic [15:0] addr, input logic [7:0] data,
                           input int chk, input logic [7:0] exp);
    t_name[n_entries] = name;
    t_kind[n_entries] = kind;
    t_op[n_entries]   = op;
    t_addr[n_entries] = addr;
    t_data[n_entries] = data;
    t_chk[n_entries]  = chk;
    t_exp[n_entries]  = exp;
    n_entries++;
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  // one byte each way, mode 0, 12 clk per sck period
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi <= tx[i];
      wait_clk(6);
      rx[i] = miso;  // master samples as sck rises
      sck <= 1'b1;
      wait_clk(6);
      sck <= 1'b0;
    end
  endtask

  task automatic run_spi(input int i);
    logic [7:0] bytes [4];
    logic [7:0] rx;
    int         n;
    bytes[0] = t_op[i];
    bytes[1] = t_addr[i][7:0];
    bytes[2] = t_addr[i][15:8];
    bytes[3] = t_data[i];
    case (t_op[i])
      bram_poke: n = 4;
      bram_peek: n = 3;
      set_led, set_full_addr: begin
        n = 2;
        bytes[1] = t_data[i];
      end
      default: n = 1;
    endcase
    if (t_kind[i] == K_ABORT)
      n = 3;  // opcode and address, data byte never sent
    cs_n <= 1'b0;
    wait_clk(6);
    for (int k = 0; k < n; k++)
      spi_xfer(bytes[k], rx);
    if (t_chk[i] == C_REPLY) begin
      wait_clk(16);
      spi_xfer(8'hff, rx);  // filler, not a known opcode
      check_byte(t_name[i], t_exp[i], rx);
    end
    wait_clk(4);
    cs_n <= 1'b1;
    wait_clk(12);
    if (t_chk[i] == C_LED)
      check_byte(t_name[i], t_exp[i], {5'b00000, led_blue, led_green, led_red});
  endtask

  task automatic z80_write(input logic [15:0] addr, input logic [7:0] data);
    a    <= addr;
    d_in <= data;
    wait_clk(2);
    wr_n <= 1'b0;
    wait_clk(16);
    wr_n <= 1'b1;
    wait_clk(8);
  endtask

  task automatic z80_read(input int i);
    a <= t_addr[i];
    wait_clk(2);
    rd_n <= 1'b0;
    wait_clk(16);  // sample at the end of the strobe
    if (t_chk[i] == C_READ) begin
      check_byte({t_name[i], " d_oe"}, 8'h01, {7'd0, d_oe});
      check_byte(t_name[i], t_exp[i], d_out);
    end else begin
      check_byte({t_name[i], " d_oe"}, 8'h00, {7'd0, d_oe});
    end
    rd_n <= 1'b1;
    wait_clk(8);
    check_byte({t_name[i], " d_oe release"}, 8'h00, {7'd0, d_oe});
  endtask

  initial begin
    logic [7:0] b [5];
    rst_n = 1'b0;
    sck   = 1'b0;
    cs_n  = 1'b1;
    mosi  = 1'b0;
    rd_n  = 1'b1;
    wr_n  = 1'b1;
    a     = '0;
    d_in  = '0;
    conf  = CONF_VAL;

    for (int k = 0; k < 5; k++)
      b[k] = rand_byte();
    if (b[4] == b[2])
      b[4] = ~b[2];  // window test needs two distinct values at 4000h

    add_entry("cookie", K_SPI, get_cookie, 16'h0000, 8'h00, C_REPLY, 8'haf);
    add_entry("version", K_SPI, get_version, 16'h0000, 8'h00, C_REPLY, 8'h03);
    add_entry("config", K_SPI, get_config, 16'h0000, 8'h00, C_REPLY, {4'h0, CONF_VAL});
    add_entry("led", K_SPI, set_led, 16'h0000, 8'h05, C_LED, 8'h05);
    add_entry("poke_1234", K_SPI, bram_poke, 16'h1234, b[0], C_NONE, 8'h00);
    add_entry("z80_rd_9234", K_RD, get_cookie, 16'h9234, 8'h00, C_READ, b[0]);
    add_entry("z80_wr_c567", K_WR, get_cookie, 16'hc567, b[1], C_NONE, 8'h00);
    add_entry("peek_4567", K_SPI, bram_peek, 16'h4567, 8'h00, C_REPLY, b[1]);
    add_entry("poke_4000", K_SPI, bram_poke, 16'h4000, b[2], C_NONE, 8'h00);
    add_entry("poke_1000", K_SPI, bram_poke, 16'h1000, b[3], C_NONE, 8'h00);
    add_entry("z80_wr_4000_off", K_WR, get_cookie, 16'h4000, b[4], C_NONE, 8'h00);
    add_entry("peek_4000_kept", K_SPI, bram_peek, 16'h4000, 8'h00, C_REPLY, b[2]);
    add_entry("z80_rd_1000_off", K_RD, get_cookie, 16'h1000, 8'h00, C_NO_OE, 8'h00);
    add_entry("full_addr_on", K_SPI, set_full_addr, 16'h0000, 8'h01, C_NONE, 8'h00);
    add_entry("z80_wr_4000_on", K_WR, get_cookie, 16'h4000, b[4], C_NONE, 8'h00);
    add_entry("peek_4000_new", K_SPI, bram_peek, 16'h4000, 8'h00, C_REPLY, b[4]);
    add_entry("z80_rd_1000_rom", K_RD, get_cookie, 16'h1000, 8'h00, C_READ, b[3]);
    add_entry("abort_poke", K_ABORT, bram_poke, 16'h1234, 8'h00, C_NONE, 8'h00);
    add_entry("peek_after_abort", K_SPI, bram_peek, 16'h1234, 8'h00, C_REPLY, b[0]);

    wait_clk(3);
    rst_n <= 1'b1;
    wait_clk(4);

    for (int i = 0; i < n_entries; i++) begin
      case (t_kind[i])
        K_SPI, K_ABORT: run_spi(i);
        K_WR:           z80_write(t_addr[i], t_data[i]);
        default:        z80_read(i);
      endcase
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
